/* source/dcache_pkg.sv */
// shared cache parameters, address and line structs, request structs and enums
package dcache_pkg;

  // geometry
  localparam int NUM_WAY     = 4;
  localparam int NUM_IDX     = 16;
  localparam int TAG_BITS    = 25;
  localparam int IDX_BITS    = 4;

  // backing memory, indexed by address bits 10:3
  localparam int MEM_LINES   = 256;
  localparam int MEM_LATENCY = 3;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] set_index;
    logic [2:0]          offset;
  } cache_addr_t;

  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TAG_BITS-1:0] tag;
    logic [63:0]         data;
  } cache_line_t;

  typedef enum logic {cmd_load, cmd_store} cpu_cmd_e;

  typedef struct packed {
    cpu_cmd_e    cmd;
    cache_addr_t addr;
    logic [63:0] data;
  } cpu_req_t;

  typedef enum logic {mem_read, mem_write} mem_cmd_e;

  typedef struct packed {
    mem_cmd_e    cmd;
    cache_addr_t addr;
    logic [63:0] data;
  } mem_req_t;

  typedef enum logic [2:0] {
    st_idle, st_evict, st_fill_req, st_fill_wait, st_install, st_respond
  } handler_state_e;

endpackage

/* source/cache_way.sv */
// one cache way: tag, data, valid and dirty arrays with tag compare and line read-out
`timescale 1ns/1ps

module cache_way import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  cache_addr_t lookup_addr,
  input  logic        install_en,
  input  cache_line_t install_line,
  output logic        hit,
  output cache_line_t line
);

  logic [NUM_IDX-1:0]  valid_q;
  logic [NUM_IDX-1:0]  dirty_q;
  logic [TAG_BITS-1:0] tag_q [NUM_IDX];
  logic [63:0]         data_q [NUM_IDX];
  logic [IDX_BITS-1:0] idx;

  assign idx = lookup_addr.set_index;

  // indexed line doubles as read data and victim content
  assign line = '{valid: valid_q[idx], dirty: dirty_q[idx], tag: tag_q[idx], data: data_q[idx]};
  assign hit  = valid_q[idx] && (tag_q[idx] == lookup_addr.tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (install_en) begin
      valid_q[idx] <= install_line.valid;
      dirty_q[idx] <= install_line.dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (install_en) begin
      tag_q[idx]  <= install_line.tag;
      data_q[idx] <= install_line.data;
    end
  end

endmodule

/* source/dcache_array.sv */
// four-way set-associative array with per-set tree pseudo-LRU and hit/victim muxes
`timescale 1ns/1ps

module dcache_array import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  cache_addr_t lookup_addr,
  input  logic        install,
  input  cache_line_t install_line,
  input  logic        update_hit_way,
  output logic        hit,
  output logic [63:0] hit_data,
  output cache_line_t victim
);

  // tree bits per set
  logic [NUM_IDX-1:0]  root_q;
  logic [NUM_IDX-1:0]  left_q;
  logic [NUM_IDX-1:0]  right_q;

  logic [IDX_BITS-1:0] set_idx;
  logic [1:0]          victim_way;
  logic [NUM_WAY-1:0]  way_hit;
  logic [NUM_WAY-1:0]  way_install;
  cache_line_t         way_line [NUM_WAY];

  assign set_idx = lookup_addr.set_index;

  // root picks the pair, the pair bit picks the way inside it
  assign victim_way = root_q[set_idx] ? {1'b1, right_q[set_idx]} : {1'b0, left_q[set_idx]};

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    // store hits rewrite the hit way, fills and allocations go to the victim
    assign way_install[w] = install &&
                            (update_hit_way ? way_hit[w] : (victim_way == 2'(w)));

    cache_way u_way (
      .clock        (clock),
      .reset        (reset),
      .lookup_addr  (lookup_addr),
      .install_en   (way_install[w]),
      .install_line (install_line),
      .hit          (way_hit[w]),
      .line         (way_line[w])
    );
  end

  assign hit    = |way_hit;
  assign victim = way_line[victim_way];

  always_comb begin
    hit_data = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (way_hit[w]) begin
        hit_data = way_line[w].data;
      end
    end
  end

  // tree advances on victim installs only
  always_ff @(posedge clock) begin
    if (reset) begin
      root_q  <= '0;
      left_q  <= '0;
      right_q <= '0;
    end else if (install && !update_hit_way) begin
      root_q[set_idx] <= ~root_q[set_idx];
      if (root_q[set_idx]) begin
        right_q[set_idx] <= ~right_q[set_idx];
      end else begin
        left_q[set_idx] <= ~left_q[set_idx];
      end
    end
  end

endmodule

/* source/miss_handler.sv */
// request FSM: lookup and hit response, victim eviction, line fill and install
`timescale 1ns/1ps

module miss_handler import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  cpu_req_t    req,
  input  logic        hit,
  input  logic [63:0] hit_data,
  input  cache_line_t victim,
  input  logic        wb_full,
  input  logic        fill_grant,
  input  logic        mem_rvalid,
  input  logic [63:0] mem_rdata,
  output cache_addr_t lookup_addr,
  output logic        install,
  output logic        update_hit_way,
  output cache_line_t install_line,
  output logic        wb_push,
  output mem_req_t    wb_entry,
  output logic        fill_req,
  output mem_req_t    fill_entry,
  output logic        busy,
  output logic        resp_valid,
  output logic        resp_hit,
  output logic [63:0] resp_data
);

  handler_state_e state_q;
  handler_state_e state_d;
  cpu_req_t       req_q;
  logic           missed_q;
  logic [63:0]    fill_q;
  logic           is_store;
  logic           victim_dirty;

  assign is_store     = (req_q.cmd == cmd_store);
  assign victim_dirty = victim.valid && victim.dirty;
  assign lookup_addr  = req_q.addr;

  // st_respond is the lookup cycle, and again the answer after an install
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_valid) state_d = st_respond;
      end
      st_respond: begin
        state_d = hit ? st_idle : st_evict;
      end
      st_evict: begin
        if (!(victim_dirty && wb_full)) state_d = is_store ? st_install : st_fill_req;
      end
      st_fill_req: begin
        if (fill_grant) state_d = st_fill_wait;
      end
      st_fill_wait: begin
        if (mem_rvalid) state_d = st_install;
      end
      st_install: begin
        state_d = st_respond;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= st_idle;
      missed_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == st_respond) begin
        missed_q <= !hit;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == st_idle && req_valid) begin
      req_q <= req;
    end
    if (mem_rvalid) begin
      fill_q <= mem_rdata;
    end
  end

  // store hit rewrites in place, misses install into the victim way
  assign update_hit_way = (state_q == st_respond);
  assign install = (state_q == st_install) ||
                   (state_q == st_respond && hit && is_store && !missed_q);
  assign install_line = '{valid: 1'b1, dirty: is_store, tag: req_q.addr.tag,
                          data: is_store ? req_q.data : fill_q};

  // victim address rebuilt from its tag and the lookup set
  assign wb_push  = (state_q == st_evict) && victim_dirty && !wb_full;
  assign wb_entry = '{cmd: mem_write,
                      addr: '{tag: victim.tag, set_index: req_q.addr.set_index, offset: 3'b0},
                      data: victim.data};

  assign fill_req   = (state_q == st_fill_req);
  assign fill_entry = '{cmd: mem_read,
                        addr: '{tag: req_q.addr.tag, set_index: req_q.addr.set_index,
                                offset: 3'b0},
                        data: 64'd0};

  assign busy       = (state_q != st_idle);
  assign resp_valid = (state_q == st_respond) && hit;
  assign resp_hit   = !missed_q;
  assign resp_data  = hit_data;

endmodule

/* source/writeback_buffer.sv */
// one-entry writeback buffer holding a dirty victim until memory accepts it
`timescale 1ns/1ps

module writeback_buffer import dcache_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  mem_req_t entry,
  input  logic     grant,
  output logic     full,
  output logic     req,
  output mem_req_t req_entry
);

  logic     full_q;
  mem_req_t entry_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (grant) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      entry_q <= entry;
    end
  end

  assign full      = full_q;
  assign req       = full_q;
  assign req_entry = entry_q;

endmodule

/* source/mem_arbiter.sv */
// fixed-priority memory port arbiter, writeback ahead of fill
`timescale 1ns/1ps

module mem_arbiter import dcache_pkg::*; (
  input  logic     wb_req,
  input  mem_req_t wb_entry,
  input  logic     fill_req,
  input  mem_req_t fill_entry,
  input  logic     mem_busy,
  output logic     wb_grant,
  output logic     fill_grant,
  output logic     mem_valid,
  output mem_req_t mem_req
);

  // writeback first so a later fill of the same line sees the new data
  assign wb_grant   = wb_req && !mem_busy;
  assign fill_grant = fill_req && !wb_req && !mem_busy;

  assign mem_valid = wb_grant || fill_grant;
  assign mem_req   = wb_req ? wb_entry : fill_entry;

endmodule

/* source/main_memory.sv */
// single-port backing memory, one-cycle writes and fixed-latency reads
`timescale 1ns/1ps

module main_memory import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_valid,
  input  mem_req_t    mem_req,
  output logic        mem_busy,
  output logic        mem_rvalid,
  output logic [63:0] mem_rdata
);

  logic [63:0]                    mem_q [MEM_LINES];
  logic [$clog2(MEM_LINES)-1:0]   line_idx;
  logic [$clog2(MEM_LINES)-1:0]   raddr_q;
  logic [$clog2(MEM_LATENCY)-1:0] count_q;
  logic                           busy_q;

  assign line_idx = mem_req.addr[10:3];

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q  <= 1'b0;
      count_q <= '0;
      for (int i = 0; i < MEM_LINES; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (mem_valid && mem_req.cmd == mem_write) begin
        mem_q[line_idx] <= mem_req.data;
      end
      if (mem_valid && mem_req.cmd == mem_read) begin
        busy_q  <= 1'b1;
        count_q <= $bits(count_q)'(MEM_LATENCY - 1);
      end else if (busy_q) begin
        if (count_q == '0) begin
          busy_q <= 1'b0;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid && mem_req.cmd == mem_read) begin
      raddr_q <= line_idx;
    end
  end

  // read data returns in the last busy cycle
  assign mem_busy   = busy_q;
  assign mem_rvalid = busy_q && (count_q == '0);
  assign mem_rdata  = mem_q[raddr_q];

endmodule

/* source/dcache_top.sv */
// data cache top: array, miss handler, writeback buffer, arbiter and memory
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  cpu_req_t    req,
  output logic        busy,
  output logic        resp_valid,
  output logic        resp_hit,
  output logic [63:0] resp_data
);

  cache_addr_t lookup_addr;
  logic        install;
  logic        update_hit_way;
  cache_line_t install_line;
  logic        hit;
  logic [63:0] hit_data;
  cache_line_t victim;

  logic        wb_push;
  mem_req_t    wb_entry;
  logic        wb_full;
  logic        wb_req;
  mem_req_t    wb_mem_entry;
  logic        wb_grant;

  logic        fill_req;
  mem_req_t    fill_entry;
  logic        fill_grant;

  logic        mem_valid;
  mem_req_t    mem_req;
  logic        mem_busy;
  logic        mem_rvalid;
  logic [63:0] mem_rdata;

  dcache_array u_array (
    .clock          (clock),
    .reset          (reset),
    .lookup_addr    (lookup_addr),
    .install        (install),
    .install_line   (install_line),
    .update_hit_way (update_hit_way),
    .hit            (hit),
    .hit_data       (hit_data),
    .victim         (victim)
  );

  miss_handler u_handler (
    .clock          (clock),
    .reset          (reset),
    .req_valid      (req_valid),
    .req            (req),
    .hit            (hit),
    .hit_data       (hit_data),
    .victim         (victim),
    .wb_full        (wb_full),
    .fill_grant     (fill_grant),
    .mem_rvalid     (mem_rvalid),
    .mem_rdata      (mem_rdata),
    .lookup_addr    (lookup_addr),
    .install        (install),
    .update_hit_way (update_hit_way),
    .install_line   (install_line),
    .wb_push        (wb_push),
    .wb_entry       (wb_entry),
    .fill_req       (fill_req),
    .fill_entry     (fill_entry),
    .busy           (busy),
    .resp_valid     (resp_valid),
    .resp_hit       (resp_hit),
    .resp_data      (resp_data)
  );

  writeback_buffer u_wb_buffer (
    .clock     (clock),
    .reset     (reset),
    .push      (wb_push),
    .entry     (wb_entry),
    .grant     (wb_grant),
    .full      (wb_full),
    .req       (wb_req),
    .req_entry (wb_mem_entry)
  );

  mem_arbiter u_arbiter (
    .wb_req     (wb_req),
    .wb_entry   (wb_mem_entry),
    .fill_req   (fill_req),
    .fill_entry (fill_entry),
    .mem_busy   (mem_busy),
    .wb_grant   (wb_grant),
    .fill_grant (fill_grant),
    .mem_valid  (mem_valid),
    .mem_req    (mem_req)
  );

  main_memory u_memory (
    .clock      (clock),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_req    (mem_req),
    .mem_busy   (mem_busy),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

endmodule

/* sim/clock_gen.sv */
// testbench clock and synchronous reset generator
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  // 100 ns period
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // reset held for 16 rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

/* sim/dcache_checker.sv */
// concurrent protocol assertions on the data cache top level, bound into dcache_top
`timescale 1ns/1ps

module dcache_checker (
  input logic clock,
  input logic reset,
  input logic busy,
  input logic resp_valid,
  input logic wb_grant,
  input logic fill_grant,
  input logic mem_valid,
  input logic mem_busy,
  input logic wb_push,
  input logic wb_full
);

  one_grant: assert property (@(posedge clock) disable iff (reset)
    !(wb_grant && fill_grant))
    else $error("arbiter granted writeback and fill in the same cycle");

  resp_in_busy: assert property (@(posedge clock) disable iff (reset)
    !resp_valid || busy)
    else $error("resp_valid pulsed while busy was low");

  // memory takes one request at a time
  mem_idle_issue: assert property (@(posedge clock) disable iff (reset)
    !(mem_valid && mem_busy))
    else $error("mem_valid issued while memory was busy");

  push_not_full: assert property (@(posedge clock) disable iff (reset)
    !(wb_push && wb_full))
    else $error("victim pushed into a full writeback buffer");

endmodule

bind dcache_top dcache_checker u_checker (
  .clock      (clock),
  .reset      (reset),
  .busy       (busy),
  .resp_valid (resp_valid),
  .wb_grant   (wb_grant),
  .fill_grant (fill_grant),
  .mem_valid  (mem_valid),
  .mem_busy   (mem_busy),
  .wb_push    (wb_push),
  .wb_full    (wb_full)
);

/* sim/dcache_tb.sv */
// data cache testbench: test file reader, request driver, response checks, timeout
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

  typedef struct packed {
    cpu_req_t    req;
    logic [63:0] exp_data;
    logic        exp_hit;
  } test_entry_t;

  logic        clock;
  logic        reset;
  logic        req_valid;
  cpu_req_t    req;
  logic        busy;
  logic        resp_valid;
  logic        resp_hit;
  logic [63:0] resp_data;

  test_entry_t tests [$];
  int          error_count;
  int          check_count;
  int          cycle_count;
  int          cycle_limit;
  logic        file_ok;

  clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  dcache_top dut (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_data  (resp_data)
  );

  // columns: cmd, address, store data, expected load data, expected hit
  task automatic load_tests();
    int          fd;
    int          fields;
    string       line_text;
    logic        cmd_v;
    logic [31:0] addr_v;
    logic [63:0] data_v;
    logic [63:0] exp_v;
    logic        hit_v;
    test_entry_t t;
    fd = $fopen("sim/dcache_tests.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open the test file sim/dcache_tests.txt");
      file_ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line_text = "";
      if ($fgets(line_text, fd) == 0) break;
      if (line_text.len() < 2 || line_text[0] == "#") continue;
      fields = $sscanf(line_text, "%h %h %h %h %h", cmd_v, addr_v, data_v, exp_v, hit_v);
      if (fields == 5) begin
        t.req.cmd  = cpu_cmd_e'(cmd_v);
        t.req.addr = cache_addr_t'(addr_v);
        t.req.data = data_v;
        t.exp_data = exp_v;
        t.exp_hit  = hit_v;
        tests.push_back(t);
      end
    end
    $fclose(fd);
    if (tests.size() == 0) begin
      error_count++;
      $display("the test file holds no requests");
      file_ok = 1'b0;
    end
  endtask

  task automatic check_response(input int num, input test_entry_t t);
    check_count++;
    assert (resp_hit == t.exp_hit) else begin
      error_count++;
      $display("[ERROR] %0t: test %0d addr %h hit flag %0b, expected %0b",
               $time, num, t.req.addr, resp_hit, t.exp_hit);
    end
    // store responses carry no data
    if (t.req.cmd == cmd_load) begin
      check_count++;
      assert (resp_data == t.exp_data) else begin
        error_count++;
        $display("[ERROR] %0t: test %0d addr %h load data %h, expected %h",
                 $time, num, t.req.addr, resp_data, t.exp_data);
      end
    end
  endtask

  // busy rises after the strobe and is low again after the response
  task automatic check_busy(input int num, input logic exp_busy);
    check_count++;
    assert (busy == exp_busy) else begin
      error_count++;
      $display("[ERROR] %0t: test %0d busy %0b, expected %0b",
               $time, num, busy, exp_busy);
    end
  endtask

  // one-cycle strobe, wait for the response pulse, then an idle gap
  task automatic run_test(input int num);
    int          gap;
    test_entry_t t;
    t = tests[num];
    while (busy) @(negedge clock);
    req       = t.req;
    req_valid = 1'b1;
    @(negedge clock);
    req_valid = 1'b0;
    check_busy(num, 1'b1);
    while (!resp_valid) @(negedge clock);
    check_response(num, t);
    @(negedge clock);
    check_busy(num, 1'b0);
    gap = $urandom % 4;
    repeat (gap) @(negedge clock);
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    req_valid   = 1'b0;
    req         = '0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    file_ok     = 1'b1;
    void'($urandom(82317));
    load_tests();
    cycle_limit = 16 + 16 * tests.size();
    if (file_ok) begin
      @(negedge clock);
      while (reset) @(negedge clock);
      foreach (tests[i]) begin
        run_test(i);
      end
    end
    $display("requests: %0d, checks: %0d, errors: %0d",
             tests.size(), check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sim/dcache_tests.txt */
# cmd (0 load, 1 store), address, store data, expected load data, expected hit
# all values hex, one request per line
0 00000010 0000000000000000 0000000000000000 0
1 00000020 1111111111111111 0000000000000000 0
0 00000020 0000000000000000 1111111111111111 1
1 00000020 2222222222222222 0000000000000000 1
0 00000020 0000000000000000 2222222222222222 1
1 00000088 aaaa0000aaaa0001 0000000000000000 0
1 00000108 bbbb0000bbbb0002 0000000000000000 0
1 00000188 cccc0000cccc0003 0000000000000000 0
1 00000208 dddd0000dddd0004 0000000000000000 0
1 00000288 eeee0000eeee0005 0000000000000000 0
0 00000108 0000000000000000 bbbb0000bbbb0002 1
0 00000088 0000000000000000 aaaa0000aaaa0001 0
0 00000108 0000000000000000 bbbb0000bbbb0002 0
0 00000188 0000000000000000 cccc0000cccc0003 0
0 00000288 0000000000000000 eeee0000eeee0005 1
1 00000030 ffff0000ffff0006 0000000000000000 0
0 000000b0 0000000000000000 0000000000000000 0
0 00000030 0000000000000000 ffff0000ffff0006 1
1 00000010 0123456789abcdef 0000000000000000 1
0 00000010 0000000000000000 0123456789abcdef 1
0 00000020 0000000000000000 2222222222222222 1

/* tb.f */
source/dcache_pkg.sv
source/cache_way.sv
source/dcache_array.sv
source/miss_handler.sv
source/writeback_buffer.sv
source/mem_arbiter.sv
source/main_memory.sv
source/dcache_top.sv
sim/clock_gen.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module dcache_tb -f tb.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
